// ==== include/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Index bits per bank
// Whole memory is 16 bytes times 2**LSU_BANK_AW
`define LSU_BANK_AW 10

// Destination tag width
// Five register bits plus two rename bits
`define LSU_RD_W 7

`endif

// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

	// Operations issued to the load/store unit
	typedef enum logic [3:0] {
		OP_NOP,
		OP_LB,
		OP_LH,
		OP_LW,
		OP_LD,
		OP_LBU,
		OP_LHU,
		OP_LWU,
		OP_SB,
		OP_SH,
		OP_SW,
		OP_SD,
		OP_FENCE,
		OP_FENCE_I
	} lsu_op_t;

	// Access size for the load path
	// SZ_NONE gives a zero result
	typedef enum logic [2:0] {
		SZ_NONE,
		SZ_BYTE,
		SZ_HALF,
		SZ_WORD,
		SZ_DOUBLE
	} lsu_size_t;

	// Load controls carried into the writeback cycle
	typedef struct packed {
		lsu_size_t  size;
		logic       usi;
		logic [2:0] offset;
		logic       odd;
	} lsu_ld_ctl_t;

	// Two bank words in address order, or the same sixteen bytes
	typedef union packed {
		logic [1:0][63:0] word;
		logic [15:0][7:0] bytes;
	} lsu_line_u;

endpackage

// ==== hw/dtcm_bank_if.sv ====
`timescale 1ns/100ps
`include "lsu_config.svh"

interface dtcm_bank_if;

	logic [`LSU_BANK_AW-1:0] addr;
	logic [63:0]             wdata;
	logic                    wen;
	logic [7:0]              wmask;
	// Read data, one cycle behind addr
	logic [63:0]             rdata;

	// Request side, drives the access
	modport requester (output addr, output wdata, output wen, output wmask);

	// RAM side
	modport memory (input addr, input wdata, input wen, input wmask, output rdata);

	// Load path only looks at the data
	modport reader (input rdata);

endinterface

// ==== hw/dtcm_bank.sv ====
`timescale 1ns/100ps
`include "lsu_config.svh"

module dtcm_bank (
	input logic         CLK,
	dtcm_bank_if.memory mem
);

	localparam int DEPTH = 2 ** `LSU_BANK_AW;

	// One 64-bit word per index
	logic [63:0] ram [0:DEPTH-1];

	// Byte lanes written under the mask
	always_ff @(posedge CLK) begin
		for (int i = 0; i < 8; i++) begin
			if (mem.wen && mem.wmask[i]) begin
				ram[mem.addr][i*8 +: 8] <= mem.wdata[i*8 +: 8];
			end
		end
	end

	// Read-first output register
	// Old word comes out when the same index is written
	always_ff @(posedge CLK) begin
		mem.rdata <= ram[mem.addr];
	end

endmodule

// ==== hw/lsu_req_split.sv ====
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_req_split import lsu_pkg::*; (
	input  logic            CLK,
	input  logic            rst,
	input  logic            in_valid,
	input  lsu_op_t         op,
	input  logic [63:0]     op1,
	input  logic [63:0]     op2,
	dtcm_bank_if.requester  bank_a,
	dtcm_bank_if.requester  bank_b,
	output lsu_ld_ctl_t     ld_ctl
);

	lsu_op_t                 op_eff;
	logic                    is_store;
	logic                    odd;
	logic [2:0]              offset;
	logic [`LSU_BANK_AW-1:0] idx;
	logic [`LSU_BANK_AW-1:0] idx_inc;
	logic [7:0]              size_mask;
	logic [15:0]             line_mask;
	logic [127:0]            line_data;
	lsu_ld_ctl_t             ld_ctl_next;

	// Idle cycles look like NOP
	assign op_eff = in_valid ? op : OP_NOP;
	assign is_store = (op_eff == OP_SB) || (op_eff == OP_SH) ||
		(op_eff == OP_SW) || (op_eff == OP_SD);

	assign odd    = op1[3];
	assign offset = op1[2:0];

	// Bank index of the access, and of the next 16-byte line
	assign idx     = op1[4 +: `LSU_BANK_AW];
	assign idx_inc = idx + 1'b1;

	// Odd start: bank A holds the upper word, one line further on
	// Index wraps at the top of the bank
	assign bank_a.addr = odd ? idx_inc : idx;
	assign bank_b.addr = idx;

	// Bytes covered by the store size
	always_comb begin
		case (op_eff)
			OP_SB:   size_mask = 8'b0000_0001;
			OP_SH:   size_mask = 8'b0000_0011;
			OP_SW:   size_mask = 8'b0000_1111;
			OP_SD:   size_mask = 8'b1111_1111;
			default: size_mask = 8'b0000_0000;
		endcase
	end

	// Place mask and data at the byte offset within a 16-byte line
	assign line_mask = {8'b0, size_mask} << offset;
	assign line_data = {64'b0, op2} << {offset, 3'b000};

	// Low half of the line goes to bank B when the start is odd
	assign bank_a.wmask = odd ? line_mask[15:8] : line_mask[7:0];
	assign bank_b.wmask = odd ? line_mask[7:0] : line_mask[15:8];
	assign bank_a.wdata = odd ? line_data[127:64] : line_data[63:0];
	assign bank_b.wdata = odd ? line_data[63:0] : line_data[127:64];

	assign bank_a.wen = is_store;
	assign bank_b.wen = is_store;

	// Load decode
	always_comb begin
		ld_ctl_next.size   = SZ_NONE;
		ld_ctl_next.usi    = 1'b0;
		ld_ctl_next.offset = offset;
		ld_ctl_next.odd    = odd;
		case (op_eff)
			OP_LB:  ld_ctl_next.size = SZ_BYTE;
			OP_LH:  ld_ctl_next.size = SZ_HALF;
			OP_LW:  ld_ctl_next.size = SZ_WORD;
			OP_LD:  ld_ctl_next.size = SZ_DOUBLE;
			OP_LBU: begin
				ld_ctl_next.size = SZ_BYTE;
				ld_ctl_next.usi  = 1'b1;
			end
			OP_LHU: begin
				ld_ctl_next.size = SZ_HALF;
				ld_ctl_next.usi  = 1'b1;
			end
			OP_LWU: begin
				ld_ctl_next.size = SZ_WORD;
				ld_ctl_next.usi  = 1'b1;
			end
			// Stores, fences and NOP read nothing
			default: ld_ctl_next.size = SZ_NONE;
		endcase
	end

	// Controls line up with bank rdata next cycle
	always_ff @(posedge CLK) begin
		if (rst) begin
			ld_ctl <= '{size: SZ_NONE, usi: 1'b0, offset: 3'b000, odd: 1'b0};
		end else begin
			ld_ctl <= ld_ctl_next;
		end
	end

endmodule

// ==== hw/lsu_load_extract.sv ====
`timescale 1ns/100ps

module lsu_load_extract import lsu_pkg::*; (
	dtcm_bank_if.reader bank_a,
	dtcm_bank_if.reader bank_b,
	input  lsu_ld_ctl_t ld_ctl,
	output logic [63:0] res
);

	lsu_line_u   line;
	logic [63:0] win;

	// Lower address word first
	always_comb begin
		if (ld_ctl.odd) begin
			line.word[0] = bank_b.rdata;
			line.word[1] = bank_a.rdata;
		end else begin
			line.word[0] = bank_a.rdata;
			line.word[1] = bank_b.rdata;
		end
	end

	// Eight lanes starting at the byte offset
	// Offset is at most 7, so the window never runs off the line
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			win[i*8 +: 8] = line.bytes[4'(ld_ctl.offset) + 4'(i)];
		end
	end

	// Size select and sign or zero extension
	always_comb begin
		case (ld_ctl.size)
			SZ_BYTE: begin
				res = ld_ctl.usi ? {56'b0, win[7:0]} : {{56{win[7]}}, win[7:0]};
			end
			SZ_HALF: begin
				res = ld_ctl.usi ? {48'b0, win[15:0]} : {{48{win[15]}}, win[15:0]};
			end
			SZ_WORD: begin
				res = ld_ctl.usi ? {32'b0, win[31:0]} : {{32{win[31]}}, win[31:0]};
			end
			SZ_DOUBLE: res = win;
			// Stores, fences, idle
			default: res = 64'b0;
		endcase
	end

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_top import lsu_pkg::*; (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 flush,
	input  logic                 in_valid,
	input  lsu_op_t              op,
	input  logic [`LSU_RD_W-1:0] rd,
	input  logic [63:0]          op1,
	input  logic [63:0]          op2,
	output logic                 wb_valid,
	output logic [`LSU_RD_W-1:0] wb_rd,
	output logic [63:0]          wb_res
);

	lsu_ld_ctl_t ld_ctl;

	// Even and odd 8-byte words
	dtcm_bank_if bank_a_if ();
	dtcm_bank_if bank_b_if ();

	// Memory always accepts, so every valid request writes back
	// Flush drops the writeback only, the store still lands
	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= in_valid & ~flush;
		end
	end

	// Tag follows its operation
	always_ff @(posedge CLK) begin
		if (in_valid) begin
			wb_rd <= rd;
		end
	end

	lsu_req_split u_req_split (
		.CLK      (CLK),
		.rst      (rst),
		.in_valid (in_valid),
		.op       (op),
		.op1      (op1),
		.op2      (op2),
		.bank_a   (bank_a_if),
		.bank_b   (bank_b_if),
		.ld_ctl   (ld_ctl)
	);

	dtcm_bank bank_a_mem (
		.CLK (CLK),
		.mem (bank_a_if)
	);

	dtcm_bank bank_b_mem (
		.CLK (CLK),
		.mem (bank_b_if)
	);

	// Result straight from the bank outputs
	lsu_load_extract u_load_extract (
		.bank_a (bank_a_if),
		.bank_b (bank_b_if),
		.ld_ctl (ld_ctl),
		.res    (wb_res)
	);

endmodule

// ==== testbench/tb_lsu.sv ====
`timescale 1ns/100ps
`include "lsu_config.svh"

module tb_lsu import lsu_pkg::*; ();

	localparam int MEM_AW = `LSU_BANK_AW + 4;
	localparam int unsigned MEM_BYTES = 16 * (2 ** `LSU_BANK_AW);
	// Random addresses stay inside the preloaded window
	localparam int WINDOW = 256;
	localparam int RT_BASE = 128;
	localparam int EXT_BASE = 32;
	// Operations issued per test group
	localparam int N_PRELOAD = WINDOW / 8;
	localparam int N_RT = 4 * 16 * 4;
	localparam int N_EXT = 2 * (2 + 6 * 8);
	localparam int N_DIRECTED = 10;
	localparam int N_RAND = 200;
	localparam int N_OPS = N_PRELOAD + N_RT + N_EXT + N_DIRECTED + N_RAND;
	localparam int TIMEOUT_NS = (N_OPS + 50) * 4;

	logic                 CLK;
	logic                 rst;
	logic                 flush;
	logic                 in_valid;
	lsu_op_t              op;
	logic [`LSU_RD_W-1:0] rd;
	logic [63:0]          op1;
	logic [63:0]          op2;
	logic                 wb_valid;
	logic [`LSU_RD_W-1:0] wb_rd;
	logic [63:0]          wb_res;

	// Byte-wide model of the whole memory
	logic [7:0] mem_model [0:MEM_BYTES-1];

	// Expected writebacks in issue order
	logic                 exp_valid_q [$];
	logic [`LSU_RD_W-1:0] exp_rd_q [$];
	logic [63:0]          exp_res_q [$];

	logic                 pending;
	logic                 mon_on;
	logic                 exp_v;
	logic [`LSU_RD_W-1:0] exp_r;
	logic [63:0]          exp_d;
	int                   errors;
	int                   checks;
	logic [31:0]          seed = 32'd55313;

	lsu_op_t store_ops [4] = '{OP_SB, OP_SH, OP_SW, OP_SD};
	lsu_op_t load_s_ops [4] = '{OP_LB, OP_LH, OP_LW, OP_LD};
	lsu_op_t load_u_ops [4] = '{OP_LBU, OP_LHU, OP_LWU, OP_LD};
	lsu_op_t ext_ops [6] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWU};

	lsu_top UUT (
		.CLK      (CLK),
		.rst      (rst),
		.flush    (flush),
		.in_valid (in_valid),
		.op       (op),
		.rd       (rd),
		.op1      (op1),
		.op2      (op2),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_res   (wb_res)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// LCG returning the upper halves of two steps
	function automatic logic [31:0] rand32();
		logic [31:0] hi;
		logic [31:0] lo;
		seed = seed * 32'd1103515245 + 32'd12345;
		hi = seed;
		seed = seed * 32'd1103515245 + 32'd12345;
		lo = seed;
		return {hi[31:16], lo[31:16]};
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		hi = rand32();
		return {hi, rand32()};
	endfunction

	// Access width in bytes or zero for fences and NOP
	function automatic int op_bytes(lsu_op_t o);
		case (o)
			OP_LB, OP_LBU, OP_SB: return 1;
			OP_LH, OP_LHU, OP_SH: return 2;
			OP_LW, OP_LWU, OP_SW: return 4;
			OP_LD, OP_SD:         return 8;
			default:              return 0;
		endcase
	endfunction

	// Addresses wrap modulo the memory size
	function automatic logic [MEM_AW-1:0] byte_index(logic [63:0] a, int i);
		return MEM_AW'(a + 64'(i));
	endfunction

	// Little-endian bytes from the model with extension
	function automatic logic [63:0] model_load(lsu_op_t o, logic [63:0] a);
		lsu_line_u   view;
		logic [63:0] val;
		int          n;
		n = op_bytes(o);
		view = '0;
		val = '0;
		if (o inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU}) begin
			for (int i = 0; i < n; i++) begin
				view.bytes[i] = mem_model[byte_index(a, i)];
			end
			val = view.word[0];
			// Signed loads copy the top loaded bit upward
			if ((o inside {OP_LB, OP_LH, OP_LW}) && val[8*n-1]) begin
				val = val | ({64{1'b1}} << (8 * n));
			end
		end
		return val;
	endfunction

	function automatic void model_store(lsu_op_t o, logic [63:0] a, logic [63:0] d);
		int n;
		n = op_bytes(o);
		for (int i = 0; i < n; i++) begin
			mem_model[byte_index(a, i)] = d[8*i +: 8];
		end
	endfunction

	task automatic report_mismatch(string name, logic [63:0] expv, logic [63:0] got);
		errors++;
		$display("mismatch %s: expected %h, got %h at %0t", name, expv, got, $time);
	endtask

	// Drives one operation and queues its expected writeback
	task automatic issue(lsu_op_t o, logic [63:0] a, logic [63:0] d, logic f);
		logic [`LSU_RD_W-1:0] r;
		r = `LSU_RD_W'(rand32());
		@(posedge CLK);
		in_valid <= 1'b1;
		op <= o;
		rd <= r;
		op1 <= a;
		op2 <= d;
		flush <= f;
		exp_valid_q.push_back(!f);
		exp_rd_q.push_back(r);
		exp_res_q.push_back(model_load(o, a));
		// Flushed stores still land
		if (o inside {OP_SB, OP_SH, OP_SW, OP_SD}) begin
			model_store(o, a, d);
		end
	endtask

	task automatic idle(int n);
		repeat (n) begin
			@(posedge CLK);
			in_valid <= 1'b0;
			flush <= 1'b0;
			op <= OP_NOP;
		end
	endtask

	// Outputs settle by the falling edge
	always @(negedge CLK) begin
		if (mon_on) begin
			if (pending) begin
				exp_v = exp_valid_q.pop_front();
				exp_r = exp_rd_q.pop_front();
				exp_d = exp_res_q.pop_front();
				checks++;
				assert (wb_valid === exp_v)
				else report_mismatch("wb_valid", 64'(exp_v), 64'(wb_valid));
				if (exp_v) begin
					assert (wb_rd === exp_r)
					else report_mismatch("wb_rd", 64'(exp_r), 64'(wb_rd));
					assert (wb_res === exp_d)
					else report_mismatch("wb_res", exp_d, wb_res);
				end
			end else begin
				// Reset and idle cycles give no writeback
				assert (wb_valid === 1'b0)
				else report_mismatch("wb_valid", 64'd0, 64'(wb_valid));
			end
		end
		// Accepted on the coming edge unless reset is held
		pending = (in_valid === 1'b1) && (rst === 1'b0);
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		logic [63:0] a;
		logic [63:0] d;
		lsu_op_t     o;
		logic        f;
		errors = 0;
		checks = 0;
		mon_on = 1'b0;
		pending = 1'b0;
		rst <= 1'b1;
		flush <= 1'b0;
		// Valid held high through reset still gives no writeback
		in_valid <= 1'b1;
		op <= OP_NOP;
		rd <= '0;
		op1 <= '0;
		op2 <= '0;
		@(posedge CLK);
		mon_on = 1'b1;
		repeat (2) @(posedge CLK);
		rst <= 1'b0;
		in_valid <= 1'b0;

		// Fill the window so every load sees defined bytes
		for (int i = 0; i < N_PRELOAD; i++) begin
			issue(OP_SD, 64'(i * 8), rand64(), 1'b0);
		end

		// Every size at every line offset with the load right behind the store
		for (int s = 0; s < 4; s++) begin
			for (int off = 0; off < 16; off++) begin
				a = 64'(RT_BASE + off);
				d = rand64();
				d[8*op_bytes(store_ops[s])-1] = off[0];
				issue(store_ops[s], a, d, 1'b0);
				if (off[1]) begin
					issue(load_u_ops[s], a, 64'd0, 1'b0);
				end else begin
					issue(load_s_ops[s], a, 64'd0, 1'b0);
				end
				// Neighbours on both sides stay intact
				issue(OP_LD, a - 64'd4, 64'd0, 1'b0);
				issue(OP_LD, a + 64'd4, 64'd0, 1'b0);
			end
		end

		// Sign and zero extension with top bits set then clear
		for (int p = 0; p < 2; p++) begin
			for (int w = 0; w < 2; w++) begin
				d = rand64();
				d = (p == 0) ? (d | 64'h8080_8080_8080_8080)
					: (d & 64'h7f7f_7f7f_7f7f_7f7f);
				issue(OP_SD, 64'(EXT_BASE + w * 8), d, 1'b0);
			end
			for (int off = 0; off < 8; off++) begin
				for (int k = 0; k < 6; k++) begin
					issue(ext_ops[k], 64'(EXT_BASE + off), 64'd0, 1'b0);
				end
			end
		end

		// Flushed store across the bank boundary and a flushed load after it
		issue(OP_SW, 64'd94, rand64(), 1'b1);
		issue(OP_LW, 64'd94, 64'd0, 1'b1);
		issue(OP_LWU, 64'd94, 64'd0, 1'b0);
		idle(1);
		issue(OP_LD, 64'd92, 64'd0, 1'b0);

		// Top of memory wraps to byte zero and upper address bits are ignored
		issue(OP_SD, 64'hffff_ffff_ffff_fffc, rand64(), 1'b0);
		issue(OP_LD, 64'(MEM_BYTES - 4), 64'd0, 1'b0);
		issue(OP_LW, 64'd0, 64'd0, 1'b0);

		issue(OP_FENCE, 64'd8, rand64(), 1'b0);
		issue(OP_FENCE_I, 64'd16, rand64(), 1'b0);

		// Back-to-back random mix
		for (int i = 0; i < N_RAND; i++) begin
			o = lsu_op_t'(4'(rand32() % 14));
			a = 64'(rand32() % (WINDOW - 8));
			d = rand64();
			f = ((rand32() % 8) == 0);
			issue(o, a, d, f);
		end
		idle(2);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+include
hw/lsu_pkg.sv
hw/dtcm_bank_if.sv
hw/dtcm_bank.sv
hw/lsu_req_split.sv
hw/lsu_load_extract.sv
hw/lsu_top.sv
testbench/tb_lsu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_lsu -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
